// ==== common/fetch_pkg.sv ====
package fetch_pkg;

	// Widths of the fetch datapath.
	localparam int unsigned WORD_BITS = 32;
	localparam int unsigned ADDR_BITS = 32;
	localparam int unsigned LINE_BITS = 2 * WORD_BITS;

	// Instruction or bus data word.
	typedef logic [WORD_BITS-1:0] word_t;

	// Byte address, word-aligned throughout the fetch path.
	typedef logic [ADDR_BITS-1:0] addr_t;

	// Cache line with data in the upper word and the tag in the lower word.
	typedef logic [LINE_BITS-1:0] line_t;

	// Low two bits of a stored tag.
	// A cleared line is all zeros and so never matches a valid tag.
	localparam logic [1:0] LINE_VALID = 2'b01;

	// Cache controller states.
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		LOOKUP   = 2'd1,
		BUS_WAIT = 2'd2,
		CLEAR    = 2'd3
	} icache_state_t;

endpackage

// ==== icache/icache_ram.sv ====
`timescale 1ns/10ps

module icache_ram #(
	parameter int INDEX_BITS = 6
) (
	input  logic                  i_clock,
	input  logic                  i_write,
	input  logic [INDEX_BITS-1:0] i_index,
	input  fetch_pkg::line_t      i_wdata,
	output fetch_pkg::line_t      o_rdata
);
	import fetch_pkg::*;

	localparam int unsigned LINES = 1 << INDEX_BITS;

	line_t mem [LINES];

	// Registered read, write-first.
	// Either way the port answers one cycle after the index.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
			o_rdata <= i_wdata;
		end
		else begin
			o_rdata <= mem[i_index];
		end
	end

endmodule

// ==== icache/icache.sv ====
`timescale 1ns/10ps

module icache #(
	parameter int INDEX_BITS = 6
) (
	input  logic             i_clock,
	input  logic             i_reset,

	// Fetch side.
	input  fetch_pkg::addr_t i_fetch_addr,
	input  logic             i_stall,
	output logic             o_word_ready,
	output fetch_pkg::word_t o_word,

	// Memory bus.
	output logic             o_bus_request,
	output fetch_pkg::addr_t o_bus_address,
	input  logic             i_bus_ready,
	input  fetch_pkg::word_t i_bus_rdata
);
	import fetch_pkg::*;

	localparam int unsigned LINES = 1 << INDEX_BITS;
	localparam logic [INDEX_BITS:0] CLEAR_END = (INDEX_BITS + 1)'(LINES);
	localparam logic [31:0] WORD_STEP = 32'd4;

	icache_state_t state;

	// Sweep counter, one bit wider than the index.
	logic [INDEX_BITS:0] clear_count;
	logic                clear_done;

	// Address whose line is on the RAM output in LOOKUP.
	addr_t lookup_addr;
	addr_t next_lookup;

	// Address the program counter will hold next cycle.
	addr_t next_fetch;
	logic  in_sync;
	logic  tag_hit;

	addr_t miss_addr;

	// Pending word, held one cycle.
	logic  word_valid;
	addr_t word_addr;

	logic                  ram_write;
	logic [INDEX_BITS-1:0] ram_index;
	line_t                 ram_wdata;
	line_t                 ram_rdata;

	function automatic addr_t make_tag(input addr_t addr);
		return {addr[31:2], LINE_VALID};
	endfunction

	function automatic logic [INDEX_BITS-1:0] line_index(input addr_t addr);
		return addr[INDEX_BITS+1:2];
	endfunction

	icache_ram #(
		.INDEX_BITS(INDEX_BITS)
	) u_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	// The word only goes out while the counter still points at it.
	// After a redirect the address differs and the word is dropped here.
	assign o_word_ready = word_valid && (word_addr == i_fetch_addr);

	assign next_fetch = o_word_ready ? i_fetch_addr + WORD_STEP : i_fetch_addr;
	assign next_lookup = lookup_addr + WORD_STEP;
	assign in_sync = (next_fetch == lookup_addr);
	assign tag_hit = (ram_rdata[31:0] == make_tag(lookup_addr));
	assign clear_done = (clear_count == CLEAR_END);

	// Miss address stays put for the whole request.
	assign o_bus_address = miss_addr;

	// RAM index per state.
	// In LOOKUP the next line is read ahead so that hits stream.
	always_comb begin
		case (state)
			CLEAR:    ram_index = clear_count[INDEX_BITS-1:0];
			IDLE:     ram_index = line_index(next_fetch);
			LOOKUP:   ram_index = line_index(next_lookup);
			BUS_WAIT: ram_index = line_index(miss_addr);
			default:  ram_index = '0;
		endcase
	end

	always_comb begin
		ram_write = 1'b0;
		ram_wdata = '0;
		if (state == CLEAR) begin
			ram_write = !clear_done;
		end
		else if ((state == BUS_WAIT) && i_bus_ready) begin
			ram_write = 1'b1;
			ram_wdata = {i_bus_rdata, make_tag(miss_addr)};
		end
	end

	// Control state.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CLEAR;
			clear_count <= '0;
			o_bus_request <= 1'b0;
			word_valid <= 1'b0;
		end
		else begin
			word_valid <= 1'b0;
			case (state)
				CLEAR: begin
					if (clear_done) begin
						clear_count <= '0;
						state <= IDLE;
					end
					else begin
						clear_count <= clear_count + 1'b1;
					end
				end

				IDLE: begin
					if (!i_stall) begin
						state <= LOOKUP;
					end
				end

				LOOKUP: begin
					// Back off on stall or when a redirect moved the counter.
					if (i_stall || !in_sync) begin
						state <= IDLE;
					end
					else if (tag_hit) begin
						word_valid <= 1'b1;
					end
					else begin
						o_bus_request <= 1'b1;
						state <= BUS_WAIT;
					end
				end

				BUS_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						word_valid <= 1'b1;
						state <= IDLE;
					end
				end

				default: state <= CLEAR;
			endcase
		end
	end

	// Addresses and data.
	always_ff @(posedge i_clock) begin
		case (state)
			IDLE: lookup_addr <= next_fetch;

			LOOKUP: begin
				if (!i_stall && in_sync) begin
					if (tag_hit) begin
						word_addr <= lookup_addr;
						o_word <= ram_rdata[63:32];
						lookup_addr <= next_lookup;
					end
					else begin
						miss_addr <= lookup_addr;
					end
				end
			end

			BUS_WAIT: begin
				if (i_bus_ready) begin
					word_addr <= miss_addr;
					o_word <= i_bus_rdata;
				end
			end

			default: ;
		endcase
	end

endmodule

// ==== verilog/fetch_pc.sv ====
`timescale 1ns/10ps

module fetch_pc (
	input  logic             i_clock,
	input  logic             i_reset,

	// One pulse per word delivered by the cache.
	input  logic             i_word_ready,

	// Redirect from outside the fetch unit.
	input  logic             i_redirect,
	input  fetch_pkg::addr_t i_redirect_addr,

	output fetch_pkg::addr_t o_fetch_addr
);

	// Byte step of one instruction word.
	localparam logic [31:0] WORD_STEP = 32'd4;

	// Reset vector.
	localparam logic [31:0] RESET_ADDR = 32'h0000_0000;

	// Redirect wins over a delivered word.
	// A word that arrives in the redirect cycle is thrown away
	// by the queue, so the counter must not step past the target.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_fetch_addr <= RESET_ADDR;
		end
		else if (i_redirect) begin
			// Keep the address word-aligned whatever the source sends.
			o_fetch_addr <= {i_redirect_addr[31:2], 2'b00};
		end
		else if (i_word_ready) begin
			o_fetch_addr <= o_fetch_addr + WORD_STEP;
		end
	end

endmodule

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/10ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic             i_clock,
	input  logic             i_reset,
	input  logic             i_flush,

	// Write side, from the cache.
	input  logic             i_push,
	input  fetch_pkg::addr_t i_push_addr,
	input  fetch_pkg::word_t i_push_word,
	output logic             o_stall,

	// Read side, to decode.
	output logic             o_valid,
	output fetch_pkg::addr_t o_addr,
	output fetch_pkg::word_t o_word,
	input  logic             i_pop_stall
);
	import fetch_pkg::*;

	localparam int unsigned PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int unsigned COUNT_BITS = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(QUEUE_DEPTH - 1);
	localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(QUEUE_DEPTH);

	// Stall once fewer than two slots are free.
	localparam logic [COUNT_BITS-1:0] STALL_COUNT = COUNT_BITS'(QUEUE_DEPTH - 2);

	addr_t addr_mem [QUEUE_DEPTH];
	word_t word_mem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0]   wr_ptr;
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  push_ok;
	logic                  pop_ok;

	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	// Nothing is shown to decode while a flush is under way.
	assign o_valid = (count != '0) && !i_flush;
	assign o_addr = addr_mem[rd_ptr];
	assign o_word = word_mem[rd_ptr];
	assign o_stall = (count > STALL_COUNT);

	assign push_ok = i_push && !i_flush && (count != FULL_COUNT);
	assign pop_ok = o_valid && !i_pop_stall;

	always_ff @(posedge i_clock) begin
		if (i_reset || i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (push_ok) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop_ok) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push_ok) begin
			addr_mem[wr_ptr] <= i_push_addr;
			word_mem[wr_ptr] <= i_push_word;
		end
	end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
	parameter int INDEX_BITS  = 6,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic             i_clock,
	input  logic             i_reset,

	// Redirect from execute.
	input  logic             i_redirect,
	input  fetch_pkg::addr_t i_redirect_addr,

	// Decode side.
	input  logic             i_decode_stall,
	output logic             o_instr_valid,
	output fetch_pkg::addr_t o_instr_addr,
	output fetch_pkg::word_t o_instr,

	// Memory bus.
	output logic             o_bus_request,
	output fetch_pkg::addr_t o_bus_address,
	input  logic             i_bus_ready,
	input  fetch_pkg::word_t i_bus_rdata
);
	import fetch_pkg::*;

	addr_t fetch_addr;
	logic  word_ready;
	word_t word;
	logic  queue_stall;

	fetch_pc u_pc (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_word_ready(word_ready),
		.i_redirect(i_redirect),
		.i_redirect_addr(i_redirect_addr),
		.o_fetch_addr(fetch_addr)
	);

	icache #(
		.INDEX_BITS(INDEX_BITS)
	) u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_addr(fetch_addr),
		.i_stall(queue_stall),
		.o_word_ready(word_ready),
		.o_word(word),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	// Redirect doubles as the queue flush.
	fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_flush(i_redirect),
		.i_push(word_ready),
		.i_push_addr(fetch_addr),
		.i_push_word(word),
		.o_stall(queue_stall),
		.o_valid(o_instr_valid),
		.o_addr(o_instr_addr),
		.o_word(o_instr),
		.i_pop_stall(i_decode_stall)
	);

endmodule

// ==== verification/tb_bus_memory.sv ====
`timescale 1ns/10ps

module tb_bus_memory #(
	parameter int SLOT_BITS = 12
) (
	input  logic             i_clock,
	input  logic             i_reset,
	input  logic             i_request,
	input  fetch_pkg::addr_t i_address,
	output logic             o_ready,
	output fetch_pkg::word_t o_rdata
);
	import fetch_pkg::*;

	localparam int MEM_WORDS = 1 << SLOT_BITS;
	localparam word_t DATA_KEY = 32'h5a3c_96e1;

	// Completed bus transactions, per word address and in total.
	int unsigned fetch_count [MEM_WORDS];
	int unsigned request_total;

	logic        busy;
	int unsigned wait_left;

	// Memory contents are the address XOR a key, rotated left by 7.
	function automatic word_t word_at(input addr_t addr);
		word_t mixed;
		mixed = addr ^ DATA_KEY;
		return {mixed[24:0], mixed[31:25]};
	endfunction

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
			busy <= 1'b0;
			wait_left <= 0;
		end
		else begin
			o_ready <= 1'b0;
			if (busy) begin
				if (wait_left <= 1) begin
					o_ready <= 1'b1;
					o_rdata <= word_at(i_address);
					busy <= 1'b0;
					fetch_count[i_address[SLOT_BITS+1:2]] <=
						fetch_count[i_address[SLOT_BITS+1:2]] + 1;
					request_total <= request_total + 1;
				end
				else begin
					wait_left <= wait_left - 1;
				end
			end
			else if (i_request && !o_ready) begin
				// New request, pick a wait of 1 to 4 cycles.
				busy <= 1'b1;
				wait_left <= 1 + $urandom % 4;
			end
		end
	end

endmodule

// ==== verification/tb_fetch_top.sv ====
`timescale 1ns/10ps

module tb_fetch_top;
	import fetch_pkg::*;

	localparam int INDEX_BITS = 6;
	localparam int QUEUE_DEPTH = 4;
	localparam int RESET_CYCLES = 10;
	localparam int STALL_PERCENT = 30;
	localparam int SLOT_BITS = 12;
	localparam logic [31:0] SEED = 32'h8176f7e5;

	// Test lengths.
	localparam int STREAM_WORDS = 40;
	localparam int LOOP_WORDS = 16;
	localparam int LOOP_PASSES = 3;
	localparam int CONFLICT_VISITS = 4;
	localparam int JUMPS = 20;
	localparam int JUMP_MAX_WORDS = 5;

	localparam addr_t LOOP_BASE = 32'h0000_0480;
	localparam addr_t CONFLICT_A = 32'h0000_0800;
	// One cache span higher, so the same line index.
	localparam addr_t CONFLICT_B = CONFLICT_A + (4 << INDEX_BITS);
	localparam addr_t JUMP_BASE = 32'h0000_1000;
	localparam word_t DATA_KEY = 32'h5a3c_96e1;

	// Lookup, longest bus wait, strobe and queue for one word.
	localparam int MISS_CYCLES = 12;
	localparam int TOTAL_WORDS = STREAM_WORDS + LOOP_WORDS * (LOOP_PASSES + 1)
		+ 2 * CONFLICT_VISITS + JUMPS * JUMP_MAX_WORDS;
	localparam int TOTAL_REDIRECTS = LOOP_PASSES + 1 + 2 * CONFLICT_VISITS + JUMPS;
	localparam int CYCLE_LIMIT = 2 * ((1 << INDEX_BITS) + 1) + 3 * RESET_CYCLES
		+ 2 * MISS_CYCLES * (TOTAL_WORDS + TOTAL_REDIRECTS);

	logic        clock = 1'b0;
	logic        reset = 1'b1;
	logic        redirect = 1'b0;
	addr_t       redirect_addr = '0;
	logic        decode_stall = 1'b0;
	logic        instr_valid;
	addr_t       instr_addr;
	word_t       instr;
	logic        bus_request;
	addr_t       bus_address;
	logic        bus_ready;
	word_t       bus_rdata;

	// Reference model and bookkeeping.
	addr_t       exp_addr = '0;
	int unsigned words_seen = 0;
	int unsigned errors = 0;
	int unsigned cycles = 0;
	logic        last_request = 1'b0;
	addr_t       last_bus_address = '0;
	int unsigned snapshot [LOOP_WORDS];

	fetch_top #(
		.INDEX_BITS(INDEX_BITS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_redirect(redirect),
		.i_redirect_addr(redirect_addr),
		.i_decode_stall(decode_stall),
		.o_instr_valid(instr_valid),
		.o_instr_addr(instr_addr),
		.o_instr(instr),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	tb_bus_memory #(
		.SLOT_BITS(SLOT_BITS)
	) u_mem (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(bus_request),
		.i_address(bus_address),
		.o_ready(bus_ready),
		.o_rdata(bus_rdata)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		decode_stall <= ($urandom % 100) < STALL_PERCENT;
	end

	function automatic word_t expected_word(input addr_t addr);
		word_t mixed;
		mixed = addr ^ DATA_KEY;
		return {mixed[24:0], mixed[31:25]};
	endfunction

	function automatic int unsigned fetches_of(input addr_t addr);
		return u_mem.fetch_count[addr[SLOT_BITS+1:2]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic redirect_to(input addr_t target);
		@(posedge clock);
		redirect <= 1'b1;
		redirect_addr <= target;
		@(posedge clock);
		redirect <= 1'b0;
	endtask

	task automatic wait_words(input int unsigned count);
		int unsigned target;
		target = words_seen + count;
		while (words_seen < target) begin
			@(posedge clock);
		end
	endtask

	task automatic apply_reset(input int held);
		@(posedge clock);
		reset <= 1'b1;
		repeat (held) @(posedge clock);
		reset <= 1'b0;
	endtask

	task automatic print_counts();
		$display("errors %0d, words checked %0d, bus requests %0d",
			errors, words_seen, u_mem.request_total);
	endtask

	// Decode side model, sampled mid-cycle where inputs and outputs are settled.
	always @(negedge clock) begin
		if (reset) begin
			exp_addr = '0;
			last_request = 1'b0;
		end
		else begin
			if (instr_valid && !decode_stall) begin
				check_value("o_instr_addr", exp_addr, instr_addr);
				check_value("o_instr", expected_word(exp_addr), instr);
				exp_addr = exp_addr + 4;
				words_seen++;
			end
			if (redirect) begin
				exp_addr = redirect_addr;
			end
			// Bus address must hold while the request is up.
			if (bus_request && last_request) begin
				check_value("o_bus_address", last_bus_address, bus_address);
			end
			last_request = bus_request;
			last_bus_address = bus_address;
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped at the limit of %0d cycles, fetch made no progress",
				CYCLE_LIMIT);
			print_counts();
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		addr_t       target;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("o_bus_request", 32'd0, 32'(bus_request));
		check_value("o_instr_valid", 32'd0, 32'(instr_valid));

		// Stream from the reset vector. Every word is a cold miss.
		wait_words(STREAM_WORDS);
		for (int i = 0; i < STREAM_WORDS; i++) begin
			check_value($sformatf("requests for %h", 4 * i), 1, fetches_of(addr_t'(4 * i)));
		end

		// Loop that fits in the cache, later passes all hit.
		for (int p = 0; p < LOOP_PASSES; p++) begin
			redirect_to(LOOP_BASE);
			wait_words(LOOP_WORDS);
		end
		for (int i = 0; i < LOOP_WORDS; i++) begin
			snapshot[i] = fetches_of(LOOP_BASE + 4 * i);
			check_value($sformatf("loop requests for %h", LOOP_BASE + 4 * i), 1, snapshot[i]);
		end

		// Reset clears the lines, so the loop misses once more.
		apply_reset(RESET_CYCLES);
		redirect_to(LOOP_BASE);
		wait_words(LOOP_WORDS);
		for (int i = 0; i < LOOP_WORDS; i++) begin
			check_value($sformatf("requests after reset for %h", LOOP_BASE + 4 * i),
				snapshot[i] + 1, fetches_of(LOOP_BASE + 4 * i));
		end

		// Two addresses on one line evict each other.
		for (int v = 0; v < CONFLICT_VISITS; v++) begin
			redirect_to(CONFLICT_A);
			wait_words(1);
			redirect_to(CONFLICT_B);
			wait_words(1);
		end
		check_value("requests for conflict A", CONFLICT_VISITS, fetches_of(CONFLICT_A));
		check_value("requests for conflict B", CONFLICT_VISITS, fetches_of(CONFLICT_B));

		// Random jumps, some before any word of the last target arrived.
		for (int j = 0; j < JUMPS; j++) begin
			target = JUMP_BASE + 4 * ($urandom % 1024);
			redirect_to(target);
			wait_words($urandom % (JUMP_MAX_WORDS + 1));
		end
		wait_words(2);

		print_counts();
		if (errors == 0) begin
			$display("PASS: all tests");
		end
		else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
common/fetch_pkg.sv
icache/icache_ram.sv
icache/icache.sv
verilog/fetch_pc.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
verification/tb_bus_memory.sv
verification/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
	--timescale 1ns/10ps \
	-f compile.f \
	--top-module tb_fetch_top \
	--Mdir "$BUILD_DIR" \
	-o tb_fetch_top

"./$BUILD_DIR/tb_fetch_top" | tee "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
